//--- Bender.yml
package:
  name: h_scaler

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/scaler_video_pkg.sv
      - src/scaler_cfg_pkg.sv
      - src/bilinear_coe_table.sv
      - src/h_scaler.sv
      - src/scale_cfg_regs.sv
      - src/h_scaler_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/h_scaler_assert.sv
      - tests/h_scaler_tb.sv

//--- compile.f
+incdir+include
src/scaler_video_pkg.sv
src/scaler_cfg_pkg.sv
src/bilinear_coe_table.sv
src/h_scaler.sv
src/scale_cfg_regs.sv
src/h_scaler_top.sv
tests/h_scaler_assert.sv
tests/h_scaler_tb.sv

//--- include/scaler_macros.svh
`ifndef SCALER_MACROS_SVH
`define SCALER_MACROS_SVH

// one colour channel sample
`define SCALER_PIXEL_WIDTH 12

// blend weight, 1.0 maps to 1024
`define SCALER_COE_WIDTH 10

// unsigned fixed point step, 4096 is 1.0
`define SCALER_UNITY_STEP 4096

// input and output position counters
`define SCALER_POS_WIDTH 24

// table index, top bits of the 12-bit fraction
`define SCALER_FRAC_BITS 8

// supported step range, 0.5 up to 4.0
`define SCALER_MIN_STEP 2048
`define SCALER_MAX_STEP 16384

`endif

//--- src/bilinear_coe_table.sv
`default_nettype none

`include "scaler_macros.svh"

module bilinear_coe_table (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,
    input  wire logic [`SCALER_FRAC_BITS-1:0] frac_i,
    output scaler_video_pkg::coe_t           coe_near_o,
    output scaler_video_pkg::coe_t           coe_far_o
);

    import scaler_video_pkg::*;

    localparam int ENTRIES = 2 ** `SCALER_FRAC_BITS;
    localparam int FULL_WEIGHT = 2 ** `SCALER_COE_WIDTH;
    localparam int MAX_WEIGHT = FULL_WEIGHT - 1;
    localparam int FAR_SCALE = FULL_WEIGHT / ENTRIES;

    typedef coe_t coe_rom_t [ENTRIES];

    // far weight grows linearly with the fraction
    function automatic coe_rom_t build_rom(input bit near);
        coe_rom_t rom;
        int far_w;
        for (int idx = 0; idx < ENTRIES; idx++) begin
            far_w = idx * FAR_SCALE;
            if (near) begin
                // 1024 does not fit, so position zero saturates
                rom[idx] = coe_t'((FULL_WEIGHT - far_w > MAX_WEIGHT) ?
                                  MAX_WEIGHT : FULL_WEIGHT - far_w);
            end else begin
                rom[idx] = coe_t'(far_w);
            end
        end
        return rom;
    endfunction

    localparam coe_rom_t NEAR_ROM = build_rom(1'b1);
    localparam coe_rom_t FAR_ROM = build_rom(1'b0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            coe_near_o <= '0;
            coe_far_o  <= '0;
        end else begin
            coe_near_o <= NEAR_ROM[frac_i];
            coe_far_o  <= FAR_ROM[frac_i];
        end
    end

endmodule

`default_nettype wire

//--- src/h_scaler.sv
`default_nettype none

`include "scaler_macros.svh"

module h_scaler (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,
    input  wire scaler_cfg_pkg::scale_step_t step_i,
    input  wire scaler_video_pkg::pixel_t    pix_i,
    input  wire logic                        de_i,
    input  wire logic                        hs_i,
    input  wire logic                        vs_i,
    output logic                             line_start_o,
    output scaler_video_pkg::pixel_t         pix_o,
    output logic                             de_o,
    output logic                             hs_o,
    output logic                             vs_o
);

    import scaler_video_pkg::*;

    localparam int POS_W = `SCALER_POS_WIDTH;
    localparam int FRAC_W = $clog2(`SCALER_UNITY_STEP);
    localparam int INT_W = POS_W - FRAC_W;
    localparam int PROD_W = `SCALER_PIXEL_WIDTH + `SCALER_COE_WIDTH;
    localparam int SUM_W = PROD_W + 1;

    localparam logic [POS_W-1:0] UNITY_POS = POS_W'(`SCALER_UNITY_STEP);
    // half of one output lsb after the shift by the weight width
    localparam logic [SUM_W-1:0] ROUND_ADD = SUM_W'(2 ** (`SCALER_COE_WIDTH - 1));

    logic [POS_W-1:0] in_pos;
    logic [POS_W-1:0] out_pos;
    logic             line_start;
    logic             emit;
    logic             sol_pend;
    logic             sof_pend;

    // newest and previous accepted pixels
    pixel_t hist_new;
    pixel_t hist_old;

    // stage 1, taps captured together with the table lookup
    pixel_t tap_left;
    pixel_t tap_right;
    coe_t   coe_near;
    coe_t   coe_far;

    // stages 2 and 3
    logic [PROD_W-1:0] prod_left;
    logic [PROD_W-1:0] prod_right;
    logic [SUM_W-1:0]  sum;

    // flags following the data through stages 1 to 3
    logic [2:0] de_pipe;
    logic [2:0] hs_pipe;
    logic [2:0] vs_pipe;

    assign line_start = de_i & hs_i;
    assign line_start_o = line_start;

    // integer part of the input position is past the left tap of the output
    assign emit = {1'b0, in_pos[POS_W-1 -: INT_W]} >=
                  ({1'b0, out_pos[POS_W-1 -: INT_W]} + (INT_W + 1)'(1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            in_pos <= '0;
        end else if (line_start) begin
            in_pos <= '0;
        end else if (de_i) begin
            in_pos <= in_pos + UNITY_POS;
        end
    end

    always_ff @(posedge clk) begin
        if (de_i) begin
            hist_new <= pix_i;
            hist_old <= hist_new;
        end
    end

    // line start wins over an emit from the previous line
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_pos  <= '0;
            sol_pend <= 1'b0;
            sof_pend <= 1'b0;
        end else begin
            if (emit) begin
                out_pos  <= out_pos + POS_W'(step_i);
                sol_pend <= 1'b0;
                sof_pend <= 1'b0;
            end
            if (line_start) begin
                out_pos  <= '0;
                sol_pend <= 1'b1;
                sof_pend <= vs_i;
            end
        end
    end

    bilinear_coe_table u_coe_table (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .frac_i     (out_pos[FRAC_W-1 -: `SCALER_FRAC_BITS]),
        .coe_near_o (coe_near),
        .coe_far_o  (coe_far)
    );

    always_ff @(posedge clk) begin
        if (emit) begin
            tap_left  <= hist_old;
            tap_right <= hist_new;
        end
    end

    // multiply, then sum with rounding
    always_ff @(posedge clk) begin
        prod_left  <= coe_near * tap_left;
        prod_right <= coe_far * tap_right;
        sum        <= SUM_W'(prod_left) + SUM_W'(prod_right) + ROUND_ADD;
    end

    always_ff @(posedge clk) begin
        if (de_pipe[2]) begin
            if (sum[SUM_W-1 -: SUM_W - PROD_W] != '0) begin
                pix_o <= '1;
            end else begin
                pix_o <= sum[`SCALER_COE_WIDTH +: `SCALER_PIXEL_WIDTH];
            end
        end
    end

    // sync alignment, 4 cycles from the emit decision
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            de_pipe <= '0;
            hs_pipe <= '0;
            vs_pipe <= '0;
            de_o    <= 1'b0;
            hs_o    <= 1'b0;
            vs_o    <= 1'b0;
        end else begin
            de_pipe <= {de_pipe[1:0], emit};
            hs_pipe <= {hs_pipe[1:0], emit & sol_pend};
            vs_pipe <= {vs_pipe[1:0], emit & sof_pend};
            de_o    <= de_pipe[2];
            hs_o    <= hs_pipe[2];
            vs_o    <= vs_pipe[2];
        end
    end

endmodule

`default_nettype wire

//--- src/h_scaler_top.sv
`default_nettype none

module h_scaler_top (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,

    // configuration port, four-phase req/ack
    input  wire logic                        cfg_req_i,
    input  wire scaler_cfg_pkg::scale_step_t cfg_step_i,
    output wire logic                        cfg_ack_o,

    // video in
    input  wire scaler_video_pkg::pixel_t    pix_i,
    input  wire logic                        de_i,
    input  wire logic                        hs_i,
    input  wire logic                        vs_i,

    // video out
    output wire scaler_video_pkg::pixel_t    pix_o,
    output wire logic                        de_o,
    output wire logic                        hs_o,
    output wire logic                        vs_o
);

    import scaler_cfg_pkg::*;

    scale_step_t step_active;
    logic        line_start;

    scale_cfg_regs u_cfg (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .cfg_req_i     (cfg_req_i),
        .cfg_step_i    (cfg_step_i),
        .cfg_ack_o     (cfg_ack_o),
        .line_start_i  (line_start),
        .step_active_o (step_active)
    );

    // step switches on the line start pulse from the scaler
    h_scaler u_scaler (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .step_i       (step_active),
        .pix_i        (pix_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .line_start_o (line_start),
        .pix_o        (pix_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

endmodule

`default_nettype wire

//--- src/scale_cfg_regs.sv
`default_nettype none

`include "scaler_macros.svh"

module scale_cfg_regs (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,
    input  wire logic                        cfg_req_i,
    input  wire scaler_cfg_pkg::scale_step_t cfg_step_i,
    output logic                             cfg_ack_o,
    input  wire logic                        line_start_i,
    output scaler_cfg_pkg::scale_step_t      step_active_o
);

    import scaler_cfg_pkg::*;

    localparam scale_step_t UNITY_STEP = scale_step_t'(`SCALER_UNITY_STEP);
    localparam scale_step_t MIN_STEP = scale_step_t'(`SCALER_MIN_STEP);
    localparam scale_step_t MAX_STEP = scale_step_t'(`SCALER_MAX_STEP);

    cfg_state_t  state;
    scale_step_t step_pending;
    scale_step_t step_clamped;

    // keep the step inside 0.5 .. 4.0
    always_comb begin
        if (cfg_step_i < MIN_STEP) begin
            step_clamped = MIN_STEP;
        end else if (cfg_step_i > MAX_STEP) begin
            step_clamped = MAX_STEP;
        end else begin
            step_clamped = cfg_step_i;
        end
    end

    assign cfg_ack_o = (state == CFG_ACK_HIGH);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state        <= CFG_IDLE;
            step_pending <= UNITY_STEP;
        end else begin
            case (state)
                CFG_IDLE: begin
                    if (cfg_req_i) begin
                        step_pending <= step_clamped;
                        state        <= CFG_ACK_HIGH;
                    end
                end
                CFG_ACK_HIGH: begin
                    if (!cfg_req_i) begin
                        state <= CFG_ACK_LOW;
                    end
                end
                // ack already low, idle next
                CFG_ACK_LOW: state <= CFG_IDLE;
                default:     state <= CFG_IDLE;
            endcase
        end
    end

    // a line never sees two different steps
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            step_active_o <= UNITY_STEP;
        end else if (line_start_i) begin
            step_active_o <= step_pending;
        end
    end

endmodule

`default_nettype wire

//--- src/scaler_cfg_pkg.sv
`default_nettype none

package scaler_cfg_pkg;

    // horizontal step, unsigned fixed point with 12 fraction bits
    typedef logic [15:0] scale_step_t;

    // four-phase req/ack port
    typedef enum logic [1:0] {
        // waiting for req
        CFG_IDLE     = 2'd0,
        // step captured, ack high until req falls
        CFG_ACK_HIGH = 2'd1,
        // ack back low, one cycle before a new request
        CFG_ACK_LOW  = 2'd2
    } cfg_state_t;

endpackage

`default_nettype wire

//--- src/scaler_video_pkg.sv
`default_nettype none

`include "scaler_macros.svh"

package scaler_video_pkg;

    // one sample of the video channel
    typedef logic [`SCALER_PIXEL_WIDTH-1:0] pixel_t;

    // one bilinear weight
    // full weight would be 1024, which needs one more bit.
    // the table stores 1023 instead and relies on rounding
    typedef logic [`SCALER_COE_WIDTH-1:0] coe_t;

endpackage

`default_nettype wire

//--- tests/h_scaler_assert.sv
`default_nettype none

module h_scaler_assert (
    input wire logic clk,
    input wire logic rst_n_i,
    input wire logic cfg_req_i,
    input wire logic cfg_ack_o,
    input wire logic de_o,
    input wire logic hs_o,
    input wire logic vs_o
);

    int fail_count = 0;

    // ack only answers a request seen on the previous edge
    property ack_rise_with_req;
        @(posedge clk) disable iff (!rst_n_i)
            $rose(cfg_ack_o) |-> $past(cfg_req_i);
    endproperty

    property ack_fall_without_req;
        @(posedge clk) disable iff (!rst_n_i)
            $fell(cfg_ack_o) |-> !$past(cfg_req_i);
    endproperty

    property sync_with_de;
        @(posedge clk) disable iff (!rst_n_i)
            (hs_o || vs_o) |-> de_o;
    endproperty

    // one reset edge has already cleared the output flags
    property de_low_in_reset;
        @(posedge clk) (!rst_n_i && $past(!rst_n_i)) |-> !de_o;
    endproperty

    assert property (ack_rise_with_req) else begin
        $error("cfg ack rose while req was low");
        fail_count++;
    end
    assert property (ack_fall_without_req) else begin
        $error("cfg ack fell while req was high");
        fail_count++;
    end
    assert property (sync_with_de) else begin
        $error("output sync flag without data enable");
        fail_count++;
    end
    assert property (de_low_in_reset) else begin
        $error("output data enable high during reset");
        fail_count++;
    end

endmodule

bind h_scaler_top h_scaler_assert u_assert (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .cfg_req_i (cfg_req_i),
    .cfg_ack_o (cfg_ack_o),
    .de_o      (de_o),
    .hs_o      (hs_o),
    .vs_o      (vs_o)
);

`default_nettype wire

//--- tests/h_scaler_tb.sv
`default_nettype none

`include "scaler_macros.svh"

module h_scaler_tb;

    import scaler_video_pkg::*;
    import scaler_cfg_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int UNITY = `SCALER_UNITY_STEP;
    localparam int MAX_LEN = 40;
    localparam int DRAIN_LIMIT = 64;
    // worst case line with two idle cycles per pixel plus drain and config writes
    localparam int LINE_BUDGET = MAX_LEN * 3 + DRAIN_LIMIT + 40;
    localparam int TOTAL_LINES = 4 + 8 + 8 + 4 + 4 + 9;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_LINES * LINE_BUDGET + 200;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        cfg_req_i;
    scale_step_t cfg_step_i;
    logic        cfg_ack_o;
    pixel_t      pix_i;
    logic        de_i;
    logic        hs_i;
    logic        vs_i;
    pixel_t      pix_o;
    logic        de_o;
    logic        hs_o;
    logic        vs_o;

    logic [31:0] lfsr_state = 32'hb0ac683b;
    pixel_t      line_pix [MAX_LEN];
    // {pix, hs, vs} per output pixel
    logic [13:0] exp_q [$];
    logic [13:0] got_q [$];
    int          step_next;
    int          checks;
    int          errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    h_scaler_top dut_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cfg_req_i  (cfg_req_i),
        .cfg_step_i (cfg_step_i),
        .cfg_ack_o  (cfg_ack_o),
        .pix_i      (pix_i),
        .de_i       (de_i),
        .hs_i       (hs_i),
        .vs_i       (vs_i),
        .pix_o      (pix_o),
        .de_o       (de_o),
        .hs_o       (hs_o),
        .vs_o       (vs_o)
    );

    // outputs are stable away from the rising edge
    always @(negedge clk) begin
        if (de_o) begin
            got_q.push_back({pix_o, hs_o, vs_o});
        end
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic int take_bits(input int nbits);
        int value;
        value = 0;
        for (int b = 0; b < nbits; b++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    function automatic int clamp_step(input int step);
        if (step < `SCALER_MIN_STEP) begin
            return `SCALER_MIN_STEP;
        end
        if (step > `SCALER_MAX_STEP) begin
            return `SCALER_MAX_STEP;
        end
        return step;
    endfunction

    // bilinear reference for one line held in line_pix
    function automatic void build_expected(input int n, input int step, input bit sof);
        int pos;
        int k;
        int i;
        int f;
        int far_w;
        int near_w;
        int value;
        exp_q.delete();
        k = 0;
        pos = 0;
        while (pos < (n - 1) * UNITY) begin
            i = pos >> 12;
            f = (pos >> 4) & 255;
            far_w = 4 * f;
            near_w = (1024 - far_w > 1023) ? 1023 : 1024 - far_w;
            value = (near_w * line_pix[i] + far_w * line_pix[i + 1] + 512) >> 10;
            if (value > 4095) begin
                value = 4095;
            end
            exp_q.push_back({value[11:0], k == 0, sof && k == 0});
            k++;
            pos = k * step;
        end
    endfunction

    task automatic write_step(input int step);
        int waited;
        @(posedge clk);
        #2;
        cfg_step_i = scale_step_t'(step);
        cfg_req_i = 1'b1;
        waited = 0;
        while (!cfg_ack_o && waited < 20) begin
            @(posedge clk);
            #2;
            waited++;
        end
        checks++;
        assert (cfg_ack_o) else begin
            $display("config port raised no ack within 20 cycles at %0t", $time);
            errors++;
        end
        cfg_req_i = 1'b0;
        waited = 0;
        while (cfg_ack_o && waited < 20) begin
            @(posedge clk);
            #2;
            waited++;
        end
        checks++;
        assert (!cfg_ack_o) else begin
            $display("config port kept ack high after req fell at %0t", $time);
            errors++;
        end
        step_next = clamp_step(step);
    endtask

    task automatic compare_line();
        checks++;
        assert (got_q.size() == exp_q.size()) else begin
            $display("Mismatch at %0t: %0d outputs in line, expected %0d",
                     $time, got_q.size(), exp_q.size());
            errors++;
        end
        for (int k = 0; k < exp_q.size() && k < got_q.size(); k++) begin
            checks++;
            assert (got_q[k] === exp_q[k]) else begin
                $display("Mismatch at %0t: output %0d pix %0d hs %0b vs %0b, expected %0d %0b %0b",
                         $time, k, got_q[k][13:2], got_q[k][1], got_q[k][0],
                         exp_q[k][13:2], exp_q[k][1], exp_q[k][0]);
                errors++;
            end
        end
        got_q.delete();
    endtask

    // hot lines sit just below full scale
    task automatic run_line(input int n, input bit sof, input bit hot);
        int line_step;
        int gap;
        int waited;
        line_step = step_next;
        gap = (UNITY + line_step - 1) / line_step - 1;
        for (int j = 0; j < n; j++) begin
            line_pix[j] = hot ? pixel_t'(4095 - take_bits(3)) : pixel_t'(take_bits(12));
        end
        build_expected(n, line_step, sof);
        checks++;
        assert (got_q.size() == 0) else begin
            $display("Mismatch at %0t: %0d outputs between lines, expected 0",
                     $time, got_q.size());
            errors++;
        end
        got_q.delete();
        for (int j = 0; j < n; j++) begin
            @(posedge clk);
            #2;
            de_i = 1'b1;
            pix_i = line_pix[j];
            hs_i = (j == 0);
            vs_i = sof && (j == 0);
            repeat (gap + take_bits(1)) begin
                @(posedge clk);
                #2;
                de_i = 1'b0;
                hs_i = 1'b0;
                vs_i = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        de_i = 1'b0;
        hs_i = 1'b0;
        vs_i = 1'b0;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        // room for any surplus output to show up
        repeat (10) @(posedge clk);
        compare_line();
    endtask

    task automatic report_test(input int num, input string name, input int lines,
                               input int err_mark);
        $display("test %0d %s: %0d lines, %0d errors", num, name, lines, errors - err_mark);
    endtask

    initial begin
        int err_mark;
        int len;
        int bad_step;
        rst_n_i = 1'b0;
        cfg_req_i = 1'b0;
        cfg_step_i = scale_step_t'(UNITY);
        pix_i = '0;
        de_i = 1'b0;
        hs_i = 1'b0;
        vs_i = 1'b0;
        checks = 0;
        errors = 0;
        step_next = UNITY;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        err_mark = errors;
        write_step(UNITY);
        for (int l = 0; l < 4; l++) begin
            run_line(8 + take_bits(6) % 33, l == 0, 1'b0);
        end
        report_test(1, "unity step", 4, err_mark);

        err_mark = errors;
        for (int l = 0; l < 8; l++) begin
            write_step(UNITY + take_bits(14) % 12289);
            run_line(8 + take_bits(6) % 33, l == 0, 1'b0);
        end
        report_test(2, "downscaling", 8, err_mark);

        err_mark = errors;
        for (int l = 0; l < 8; l++) begin
            write_step(2048 + take_bits(11));
            run_line(8 + take_bits(6) % 33, l == 0, 1'b0);
        end
        report_test(3, "upscaling", 8, err_mark);

        err_mark = errors;
        for (int l = 0; l < 4; l++) begin
            write_step(2048 + take_bits(14) % 14337);
            run_line(8 + take_bits(6) % 33, l == 0, 1'b1);
        end
        report_test(4, "saturating input", 4, err_mark);

        // write lands mid-line, so the clamped step shows up one line later
        err_mark = errors;
        for (int pair = 0; pair < 2; pair++) begin
            write_step(UNITY);
            len = 8 + take_bits(6) % 33;
            bad_step = (pair == 0) ? take_bits(11) : 16385 + take_bits(15) % 49151;
            fork
                run_line(len, pair == 0, 1'b0);
                begin
                    repeat (3) @(posedge clk);
                    write_step(bad_step);
                end
            join
            run_line(8 + take_bits(6) % 33, 1'b0, 1'b0);
        end
        report_test(5, "config clamp", 4, err_mark);

        err_mark = errors;
        for (int fr = 0; fr < 3; fr++) begin
            write_step(2048 + take_bits(14) % 14337);
            for (int l = 0; l < 3; l++) begin
                run_line(8 + take_bits(6) % 33, l == 0, 1'b0);
            end
        end
        report_test(6, "sync flags", 9, err_mark);

        errors += dut_i.u_assert.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog stopped the run after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
